/* design/cnn_macros.svh */
`ifndef CNN_MACROS_SVH
`define CNN_MACROS_SVH

// Instruction word
`define CNN_INST_W   32

// Output channels computed in parallel
`define CNN_CH       4
`define CNN_CH_W     2

// 3x3 kernel
`define CNN_TAPS     9
`define CNN_TAP_W    4

// Datapath widths
`define CNN_PIX_W    8
`define CNN_ACC_W    20
`define CNN_BIAS_W   16
`define CNN_SHIFT_W  5

// Feature memory, 1024 pixels
`define CNN_FADDR_W  10

`endif

/* design/cnn_pkg.sv */
`include "cnn_macros.svh"

package cnn_pkg;

	////////////////////////////////////////
	// Instruction opcodes, bits 31..28
	////////////////////////////////////////
	typedef enum logic [3:0] {
		OP_NOP    = 4'd0,
		OP_LOAD_W = 4'd1, // Kernel weight
		OP_LOAD_B = 4'd2, // Channel bias
		OP_LOAD_F = 4'd3, // Feature pixel
		OP_CONF   = 4'd4, // Line width, shift, pool enable
		OP_RUN    = 4'd5  // One 3x3 window
	} opcode_e;

	// MAC sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE = 2'd0,
		SEQ_MAC  = 2'd1,
		SEQ_DONE = 2'd2
	} seq_state_e;

	////////////////////////////////////////
	// Per-channel vectors, channel 0 in the low bits
	////////////////////////////////////////
	typedef logic [`CNN_CH-1:0][`CNN_ACC_W-1:0]  acc_vec_t;
	typedef logic [`CNN_CH-1:0][`CNN_PIX_W-1:0]  pix_vec_t;
	typedef logic [`CNN_CH-1:0][`CNN_PIX_W-1:0]  weight_vec_t;
	typedef logic [`CNN_CH-1:0][`CNN_BIAS_W-1:0] bias_vec_t;

endpackage

/* design/inst_decode.sv */
`timescale 1ns/1ps
`include "cnn_macros.svh"

module inst_decode (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    inst_valid,
	input  logic [`CNN_INST_W-1:0]  inst,
	output logic                    w_we,
	output logic [`CNN_CH_W-1:0]    w_ch,
	output logic [`CNN_TAP_W-1:0]   w_tap,
	output logic [`CNN_PIX_W-1:0]   w_data,
	output logic                    b_we,
	output logic [`CNN_CH_W-1:0]    b_ch,
	output logic [`CNN_BIAS_W-1:0]  b_data,
	output logic                    f_we,
	output logic [`CNN_FADDR_W-1:0] f_addr,
	output logic [`CNN_PIX_W-1:0]   f_data,
	output logic                    run_start,
	output logic [`CNN_FADDR_W-1:0] run_base,
	output logic                    conf_pulse,
	output logic [`CNN_FADDR_W-1:0] line_width,
	output logic [`CNN_SHIFT_W-1:0] shift,
	output logic                    pool_en,
	output logic                    busy
);
	import cnn_pkg::*;

	// Busy from run_start up to the cycle before acc_valid
	localparam logic [3:0] BUSY_LEN = 4'(`CNN_TAPS + 2);

	opcode_e    opcode;
	logic       run_req;
	logic [3:0] busy_cnt;

	assign opcode  = opcode_e'(inst[31:28]);
	assign run_req = inst_valid && (opcode == OP_RUN);
	assign busy    = (busy_cnt != 4'd0);

	////////////////////////////////////////
	// Strobes and configuration
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			w_we       <= 1'b0;
			b_we       <= 1'b0;
			f_we       <= 1'b0;
			run_start  <= 1'b0;
			conf_pulse <= 1'b0;
			line_width <= '0;
			shift      <= '0;
			pool_en    <= 1'b0;
			busy_cnt   <= '0;
		end else begin
			w_we       <= inst_valid && (opcode == OP_LOAD_W);
			b_we       <= inst_valid && (opcode == OP_LOAD_B);
			f_we       <= inst_valid && (opcode == OP_LOAD_F);
			run_start  <= run_req;
			conf_pulse <= inst_valid && (opcode == OP_CONF);
			if (inst_valid && (opcode == OP_CONF)) begin
				line_width <= inst[25:16];
				shift      <= inst[4:0];
				pool_en    <= inst[8];
			end
			if (run_req)
				busy_cnt <= BUSY_LEN;
			else if (busy)
				busy_cnt <= busy_cnt - 1'b1;
		end
	end

	// Field payloads, qualified by the strobes above
	always_ff @(posedge clk) begin
		w_ch   <= inst[27:26];
		w_tap  <= inst[25:22];
		w_data <= inst[7:0];
		b_ch   <= inst[27:26];
		b_data <= inst[15:0];
		f_addr <= inst[25:16];
		f_data <= inst[7:0];
		if (run_req)
			run_base <= inst[25:16];
	end

	// No new window until the previous one has left the MAC
	a_no_run_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		run_req |-> !busy);

endmodule

/* design/kernel_store.sv */
`timescale 1ns/1ps
`include "cnn_macros.svh"

module kernel_store (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   w_we,
	input  logic [`CNN_CH_W-1:0]   w_ch,
	input  logic [`CNN_TAP_W-1:0]  w_tap,
	input  logic [`CNN_PIX_W-1:0]  w_data,
	input  logic                   b_we,
	input  logic [`CNN_CH_W-1:0]   b_ch,
	input  logic [`CNN_BIAS_W-1:0] b_data,
	input  logic [`CNN_TAP_W-1:0]  tap,
	output cnn_pkg::weight_vec_t   tap_weights,
	output cnn_pkg::bias_vec_t     bias_vec
);

	// Signed weights, one row of nine taps per channel
	logic [`CNN_PIX_W-1:0] w_mem [`CNN_CH][`CNN_TAPS];

	////////////////////////////////////////
	// Weight memory
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (w_we)
			w_mem[w_ch][w_tap] <= w_data;
	end

	// All channels of one tap, one cycle after tap
	always_ff @(posedge clk) begin
		for (int c = 0; c < `CNN_CH; c++) begin
			tap_weights[c] <= w_mem[c][tap];
		end
	end

	////////////////////////////////////////
	// Bias registers
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (b_we)
			bias_vec[b_ch] <= b_data; // Held until reloaded
	end

	// Decode must only address real taps
	a_tap_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		w_we |-> (w_tap < `CNN_TAPS));

endmodule

/* design/feature_buffer.sv */
`timescale 1ns/1ps
`include "cnn_macros.svh"

module feature_buffer (
	input  logic                    clk,
	input  logic                    f_we,
	input  logic [`CNN_FADDR_W-1:0] f_addr,
	input  logic [`CNN_PIX_W-1:0]   f_data,
	input  logic [`CNN_FADDR_W-1:0] run_base,
	input  logic [`CNN_FADDR_W-1:0] line_width,
	input  logic [`CNN_TAP_W-1:0]   tap,
	output logic [`CNN_PIX_W-1:0]   win_pixel
);

	logic [`CNN_PIX_W-1:0]   mem [1 << `CNN_FADDR_W];
	logic [1:0]              row;
	logic [1:0]              col;
	logic [`CNN_FADDR_W-1:0] row_off;
	logic [`CNN_FADDR_W-1:0] win_addr;

	////////////////////////////////////////
	// Window address, row-major taps
	////////////////////////////////////////
	always_comb begin
		if (tap >= 4'd6) begin
			row = 2'd2;
			col = 2'(tap - 4'd6);
		end else if (tap >= 4'd3) begin
			row = 2'd1;
			col = 2'(tap - 4'd3);
		end else begin
			row = 2'd0;
			col = 2'(tap);
		end
		case (row)
			2'd1:    row_off = line_width;
			2'd2:    row_off = {line_width[`CNN_FADDR_W-2:0], 1'b0}; // Two lines down
			default: row_off = '0;
		endcase
		win_addr = run_base + row_off + col; // Wraps at 1024
	end

	always_ff @(posedge clk) begin
		if (f_we)
			mem[f_addr] <= f_data;
		win_pixel <= mem[win_addr];
	end

endmodule

/* design/mac_sequencer.sv */
`timescale 1ns/1ps
`include "cnn_macros.svh"

module mac_sequencer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  run_start,
	output logic [`CNN_TAP_W-1:0] tap,
	input  logic [`CNN_PIX_W-1:0] win_pixel,
	input  cnn_pkg::weight_vec_t  tap_weights,
	output logic                  acc_valid,
	output cnn_pkg::acc_vec_t     acc
);
	import cnn_pkg::*;

	seq_state_e                  state;
	logic                        rd_valid; // Read data belongs to a live tap
	logic signed [`CNN_ACC_W-1:0] prod [`CNN_CH];

	////////////////////////////////////////
	// Tap sequencing
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= SEQ_IDLE;
			tap       <= '0;
			rd_valid  <= 1'b0;
			acc_valid <= 1'b0;
		end else begin
			rd_valid  <= (state == SEQ_MAC);
			acc_valid <= (state == SEQ_DONE);
			case (state)
				SEQ_IDLE: begin
					if (run_start) begin
						state <= SEQ_MAC;
						tap   <= '0;
					end
				end
				SEQ_MAC: begin
					if (tap == `CNN_TAP_W'(`CNN_TAPS - 1))
						state <= SEQ_DONE; // Last read still in flight
					else
						tap <= tap + 1'b1;
				end
				SEQ_DONE: state <= SEQ_IDLE;
				default:  state <= SEQ_IDLE;
			endcase
		end
	end

	// Unsigned pixel times signed weight, sign extended
	always_comb begin
		for (int c = 0; c < `CNN_CH; c++) begin
			prod[c] = $signed({1'b0, win_pixel}) * $signed(tap_weights[c]);
		end
	end

	////////////////////////////////////////
	// Four accumulators
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (run_start) begin
			acc <= '0;
		end else if (rd_valid) begin
			for (int c = 0; c < `CNN_CH; c++) begin
				acc[c] <= acc[c] + prod[c];
			end
		end
	end

	// Decode must hold back runs until this window is finished
	a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		run_start |-> (state == SEQ_IDLE));

endmodule

/* design/result_stage.sv */
`timescale 1ns/1ps
`include "cnn_macros.svh"

module result_stage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    acc_valid,
	input  cnn_pkg::acc_vec_t       acc,
	input  cnn_pkg::bias_vec_t      bias_vec,
	input  logic [`CNN_SHIFT_W-1:0] shift,
	input  logic                    pool_en,
	input  logic                    conf_pulse,
	output logic                    result_valid,
	output cnn_pkg::pix_vec_t       result
);
	import cnn_pkg::*;

	localparam int SAT_MAX = (1 << `CNN_PIX_W) - 1;

	logic signed [`CNN_ACC_W:0] biased  [`CNN_CH]; // One guard bit for the bias add
	logic signed [`CNN_ACC_W:0] shifted [`CNN_CH];
	pix_vec_t                   sat;
	pix_vec_t                   pool_max;
	pix_vec_t                   pool_next;
	logic [1:0]                 pool_cnt;

	////////////////////////////////////////
	// Bias, shift, ReLU, saturate
	////////////////////////////////////////
	always_comb begin
		for (int c = 0; c < `CNN_CH; c++) begin
			biased[c]  = $signed(acc[c]) + $signed(bias_vec[c]);
			shifted[c] = biased[c] >>> shift;
			if (shifted[c] < 0)
				sat[c] = '0; // ReLU
			else if (shifted[c] > SAT_MAX)
				sat[c] = '1;
			else
				sat[c] = shifted[c][`CNN_PIX_W-1:0];
			// First result of a group starts a fresh maximum
			if ((pool_cnt == 2'd0) || (sat[c] > pool_max[c]))
				pool_next[c] = sat[c];
			else
				pool_next[c] = pool_max[c];
		end
	end

	////////////////////////////////////////
	// Strobe and pooling count
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			pool_cnt     <= '0;
		end else begin
			result_valid <= acc_valid && (!pool_en || (pool_cnt == 2'd3));
			if (conf_pulse)
				pool_cnt <= '0; // New layer drops a partial group
			else if (acc_valid && pool_en)
				pool_cnt <= pool_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (conf_pulse)
			pool_max <= '0;
		else if (acc_valid && pool_en)
			pool_max <= pool_next;
		if (acc_valid)
			result <= pool_en ? pool_next : sat;
	end

endmodule

/* design/cnn_core_top.sv */
`timescale 1ns/1ps
`include "cnn_macros.svh"

module cnn_core_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   inst_valid,
	input  logic [`CNN_INST_W-1:0] inst,
	output logic                   busy,
	output logic                   result_valid,
	output cnn_pkg::pix_vec_t      result
);
	import cnn_pkg::*;

	// Decode to buffers
	logic                    w_we;
	logic [`CNN_CH_W-1:0]    w_ch;
	logic [`CNN_TAP_W-1:0]   w_tap;
	logic [`CNN_PIX_W-1:0]   w_data;
	logic                    b_we;
	logic [`CNN_CH_W-1:0]    b_ch;
	logic [`CNN_BIAS_W-1:0]  b_data;
	logic                    f_we;
	logic [`CNN_FADDR_W-1:0] f_addr;
	logic [`CNN_PIX_W-1:0]   f_data;

	// Run control and layer configuration
	logic                    run_start;
	logic [`CNN_FADDR_W-1:0] run_base;
	logic                    conf_pulse;
	logic [`CNN_FADDR_W-1:0] line_width;
	logic [`CNN_SHIFT_W-1:0] shift;
	logic                    pool_en;

	// Execute path
	logic [`CNN_TAP_W-1:0]   tap;
	logic [`CNN_PIX_W-1:0]   win_pixel;
	weight_vec_t             tap_weights;
	bias_vec_t               bias_vec;
	logic                    acc_valid;
	acc_vec_t                acc;

	////////////////////////////////////////
	inst_decode u_inst_decode (
		.clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst),
		.w_we(w_we), .w_ch(w_ch), .w_tap(w_tap), .w_data(w_data),
		.b_we(b_we), .b_ch(b_ch), .b_data(b_data),
		.f_we(f_we), .f_addr(f_addr), .f_data(f_data),
		.run_start(run_start), .run_base(run_base), .conf_pulse(conf_pulse),
		.line_width(line_width), .shift(shift), .pool_en(pool_en), .busy(busy)
	);

	kernel_store u_kernel_store (
		.clk(clk), .rst_n(rst_n),
		.w_we(w_we), .w_ch(w_ch), .w_tap(w_tap), .w_data(w_data),
		.b_we(b_we), .b_ch(b_ch), .b_data(b_data),
		.tap(tap), .tap_weights(tap_weights), .bias_vec(bias_vec)
	);

	feature_buffer u_feature_buffer (
		.clk(clk), .f_we(f_we), .f_addr(f_addr), .f_data(f_data),
		.run_base(run_base), .line_width(line_width), .tap(tap), .win_pixel(win_pixel)
	);

	mac_sequencer u_mac_sequencer (
		.clk(clk), .rst_n(rst_n), .run_start(run_start), .tap(tap),
		.win_pixel(win_pixel), .tap_weights(tap_weights),
		.acc_valid(acc_valid), .acc(acc)
	);

	result_stage u_result_stage (
		.clk(clk), .rst_n(rst_n), .acc_valid(acc_valid), .acc(acc), .bias_vec(bias_vec),
		.shift(shift), .pool_en(pool_en), .conf_pulse(conf_pulse),
		.result_valid(result_valid), .result(result)
	);

endmodule

/* bench/cnn_core_tb.sv */
`timescale 1ns/1ps
`include "cnn_macros.svh"

module cnn_core_tb;
	import cnn_pkg::*;

	localparam logic [1:0] ROW_PLAIN = 2'd0; // Load or config, nothing to check
	localparam logic [1:0] ROW_CHECK = 2'd1; // Run with a result strobe
	localparam logic [1:0] ROW_QUIET = 2'd2; // Pooled run, no strobe

	logic        clk = 1'b0;
	logic        rst_n;
	logic        inst_valid;
	logic [31:0] inst;
	logic        busy;
	logic        result_valid;
	pix_vec_t    result;

	// Stimulus table
	logic [31:0] tbl_inst [$];
	logic [1:0]  tbl_kind [$];
	logic [31:0] tbl_exp  [$];
	string       tbl_name [$];

	// Reference model state
	logic signed [7:0]  m_w [`CNN_CH][`CNN_TAPS];
	logic signed [15:0] m_b [`CNN_CH];
	logic [7:0]         m_f [1 << `CNN_FADDR_W];
	int                 m_lw, m_shift, m_pcnt;
	logic               m_pool;
	logic [31:0]        m_pmax;

	logic [31:0] lfsr;
	int          value_errs = 0;
	int          other_errs = 0;

	cnn_core_top u_cnn_core_top (
		.clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst),
		.busy(busy), .result_valid(result_valid), .result(result)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////
	// Random bits and reference model
	////////////////////////////////////////
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // x^32+x^22+x^2+x+1
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [31:0] model_window(input int base);
		logic [31:0] res;
		int          sum, addr, px, wt, v;
		res = '0;
		for (int c = 0; c < `CNN_CH; c++) begin
			sum = 0;
			for (int t = 0; t < `CNN_TAPS; t++) begin
				addr = (base + (t / 3) * m_lw + (t % 3)) % 1024; // Row-major, wraps
				px   = m_f[addr];
				wt   = m_w[c][t];
				sum += px * wt;
			end
			v = (sum + m_b[c]) >>> m_shift;
			if (v < 0)
				v = 0; // ReLU
			else if (v > 255)
				v = 255;
			res[c*8 +: 8] = v[7:0];
		end
		return res;
	endfunction

	task automatic push_row(input logic [31:0] word, input logic [1:0] kind,
			input logic [31:0] exp, input string name);
		tbl_inst.push_back(word);
		tbl_kind.push_back(kind);
		tbl_exp.push_back(exp);
		tbl_name.push_back(name);
	endtask

	task automatic load_weight(input int ch, input int tap, input logic [7:0] w);
		m_w[ch][tap] = w;
		push_row({OP_LOAD_W, 2'(ch), 4'(tap), 14'b0, w}, ROW_PLAIN, '0, "load_w");
	endtask

	task automatic load_bias(input int ch, input logic [15:0] b);
		m_b[ch] = b;
		push_row({OP_LOAD_B, 2'(ch), 10'b0, b}, ROW_PLAIN, '0, "load_b");
	endtask

	task automatic load_pixel(input int addr, input logic [7:0] px);
		m_f[addr] = px;
		push_row({OP_LOAD_F, 2'b0, 10'(addr), 8'b0, px}, ROW_PLAIN, '0, "load_f");
	endtask

	task automatic set_config(input int lw, input int sh, input logic pool);
		m_lw    = lw;
		m_shift = sh;
		m_pool  = pool;
		m_pcnt  = 0; // Partial group dropped
		m_pmax  = '0;
		push_row({OP_CONF, 2'b0, 10'(lw), 7'b0, pool, 3'b0, 5'(sh)}, ROW_PLAIN, '0, "conf");
	endtask

	task automatic queue_run(input int base, input string name);
		logic [31:0] s;
		logic [31:0] word;
		s    = model_window(base);
		word = {OP_RUN, 2'b0, 10'(base), 16'b0};
		if (!m_pool) begin
			push_row(word, ROW_CHECK, s, name);
		end else begin
			for (int c = 0; c < `CNN_CH; c++) begin
				if (m_pcnt == 0 || s[c*8 +: 8] > m_pmax[c*8 +: 8])
					m_pmax[c*8 +: 8] = s[c*8 +: 8];
			end
			m_pcnt = (m_pcnt + 1) % 4;
			push_row(word, (m_pcnt == 0) ? ROW_CHECK : ROW_QUIET, m_pmax, name);
		end
	endtask

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////
	task automatic build_table();
		logic [31:0] r;
		for (int a = 0; a < 1024; a++)
			load_pixel(a, 8'((a * 5 + (a >> 5)) % 31)); // Small image
		for (int c = 0; c < `CNN_CH; c++) begin
			for (int t = 0; t < `CNN_TAPS; t++)
				load_weight(c, t, 8'd1);
			load_bias(c, 16'd0);
		end
		set_config(16, 0, 1'b0);
		queue_run(0, "ones_base0");
		queue_run(37, "ones_base37");
		queue_run(200, "ones_base200");
		for (int a = 960; a < 1024; a++)
			load_pixel(a, 8'(rand_bits(8))); // Large pixels near the top
		// Wrapping windows and line widths
		set_config(5, 0, 1'b0);
		queue_run(1023, "wrap_lw5");
		set_config(1000, 0, 1'b0);
		queue_run(500, "wrap_lw1000");
		set_config(0, 0, 1'b0);
		queue_run(10, "lw0");
		set_config(32, 1, 1'b0);
		queue_run(990, "lw32_shift1");
		for (int it = 0; it < 6; it++) begin
			for (int c = 0; c < `CNN_CH; c++) begin
				for (int t = 0; t < `CNN_TAPS; t++)
					load_weight(c, t, 8'(rand_bits(8)));
				r = rand_bits(12);
				load_bias(c, {{4{r[11]}}, r[11:0]});
			end
			set_config(1 + int'(rand_bits(6)), int'(rand_bits(3)), 1'b0);
			queue_run(int'(rand_bits(10)), $sformatf("rand%0d_a", it));
			queue_run(int'(rand_bits(10)), $sformatf("rand%0d_b", it));
		end
		// 2x2 pooling group
		set_config(20, 2, 1'b1);
		queue_run(100, "pool_a");
		queue_run(101, "pool_b");
		queue_run(120, "pool_c");
		queue_run(121, "pool_d");
		// Single weight and bias reloads
		set_config(20, 1, 1'b0);
		queue_run(300, "reload_ref");
		load_weight(2, 4, 8'h81);
		queue_run(300, "reload_w2");
		load_bias(1, 16'hfe0c);
		queue_run(300, "reload_b1");
		// Partial group cleared by a new config
		set_config(20, 1, 1'b1);
		queue_run(300, "partial_a");
		queue_run(301, "partial_b");
		set_config(20, 1, 1'b1);
		for (int k = 0; k < 4; k++)
			queue_run(302 + k, $sformatf("regroup_%0d", k));
	endtask

	////////////////////////////////////////
	// Drive and check
	////////////////////////////////////////
	task automatic drive_inst(input logic [31:0] word);
		@(posedge clk);
		inst_valid <= 1'b1;
		inst       <= word;
		@(posedge clk);
		inst_valid <= 1'b0;
	endtask

	// Called right after the strobe cycle, so the first negedge is cycle 1
	task automatic wait_result(input logic [31:0] exp, input string name);
		int cyc;
		bit seen;
		cyc  = 1;
		seen = 0;
		while (!seen && cyc <= 40) begin
			@(negedge clk);
			// Busy covers cycles 1 to 11 of a run
			assert (busy === (cyc < 12)) else begin
				value_errs++;
				$display("ERR %s busy in cycle %0d expected %b actual %b",
					name, cyc, (cyc < 12), busy);
			end
			if (result_valid === 1'b1)
				seen = 1;
			else
				cyc++;
		end
		assert (seen) else begin
			other_errs++;
			$display("Timeout waiting for result_valid after run %s", name);
		end
		if (seen) begin
			assert (cyc == 13) else begin
				other_errs++;
				$display("Run %s: result_valid came %0d cycles after the run, not 13", name, cyc);
			end
			assert (result === exp) else begin
				value_errs++;
				$display("ERR %s expected %h actual %h", name, exp, result);
			end
			@(negedge clk);
			assert (result_valid === 1'b0 && busy === 1'b0) else begin
				other_errs++;
				$display("Run %s: result_valid longer than one cycle or busy still high", name);
			end
		end
	endtask

	task automatic watch_quiet(input string name);
		for (int k = 1; k <= 16; k++) begin
			@(negedge clk);
			assert (busy === (k < 12)) else begin
				value_errs++;
				$display("ERR %s busy in cycle %0d expected %b actual %b",
					name, k, (k < 12), busy);
			end
			assert (result_valid !== 1'b1) else begin
				other_errs++;
				$display("Pooled run %s gave a result strobe before its group was full", name);
			end
		end
	endtask

	initial begin
		rst_n      = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		lfsr       = 32'h61eb;
		build_table();
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (busy === 1'b0 && result_valid === 1'b0) else begin
			other_errs++;
			$display("busy or result_valid not low after reset");
		end
		for (int i = 0; i < tbl_inst.size(); i++) begin
			drive_inst(tbl_inst[i]);
			if (tbl_kind[i] == ROW_CHECK)
				wait_result(tbl_exp[i], tbl_name[i]);
			else if (tbl_kind[i] == ROW_QUIET)
				watch_quiet(tbl_name[i]);
		end
		repeat (4) @(posedge clk);
		$display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+design
design/cnn_pkg.sv
design/inst_decode.sv
design/kernel_store.sv
design/feature_buffer.sv
design/mac_sequencer.sv
design/result_stage.sv
design/cnn_core_top.sv
bench/cnn_core_tb.sv
